// ==== src/efpga_pkg.sv ====
// widths and counts for the eFPGA glue
// register port request and response structs

package efpga_pkg;

   localparam int DATA_W      = 32;
   localparam int BE_W        = DATA_W / 8;
   localparam int LINT_ADDR_W = 20;   // fabric register space
   localparam int CTRL_W      = 32;
   localparam int N_EVENTS    = 16;

   // cycles an enabled access waits before the fabric request
   localparam int SETTLE_CYCLES = 2;
   localparam int SETTLE_CNT_W  = $clog2(SETTLE_CYCLES + 1);
   localparam logic [SETTLE_CNT_W-1:0] SETTLE_LAST = SETTLE_CNT_W'(SETTLE_CYCLES - 1);

   // one access towards the fabric register port
   typedef struct packed {
      logic                   we;      // 1 = write
      logic [LINT_ADDR_W-1:0] addr;
      logic [BE_W-1:0]        be;
      logic [DATA_W-1:0]      wdata;
   } lint_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
   } lint_rsp_t;

endpackage

// ==== src/ctrl_word_filter.sv ====
// control word stability filter
// three equal samples needed before the word reaches the fabric
`timescale 1ns/1ps

module ctrl_word_filter (
   input  logic                           asic_clk_i,
   input  logic                           rst_n,
   input  logic [efpga_pkg::CTRL_W-1:0]   control_i,
   output logic [efpga_pkg::CTRL_W-1:0]   efpga_control_o
);

   logic [efpga_pkg::CTRL_W-1:0] ctrl_d1_q;
   logic [efpga_pkg::CTRL_W-1:0] ctrl_d2_q;
   logic                         ctrl_stable_q;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_d1_q     <= '0;
         ctrl_d2_q     <= '0;
         ctrl_stable_q <= 1'b0;
      end else begin
         ctrl_d1_q     <= control_i;
         ctrl_d2_q     <= ctrl_d1_q;
         ctrl_stable_q <= (control_i == ctrl_d1_q) && (control_i == ctrl_d2_q);
      end
   end

   // capture register, only loads a word seen three times in a row
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         efpga_control_o <= '0;
      end else if (ctrl_stable_q) begin
         efpga_control_o <= ctrl_d1_q;   // d1 still holds the stable word
      end
   end

endmodule

// ==== src/event_edge_sync.sv ====
// fabric event synchronizer and rising edge detector
// two flop sync, enable gate, one pulse per gated rise
`timescale 1ns/1ps

module event_edge_sync (
   input  logic                             asic_clk_i,
   input  logic                             rst_n,
   input  logic                             enable_events_i,
   input  logic [efpga_pkg::N_EVENTS-1:0]   fab_events_i,
   output logic [efpga_pkg::N_EVENTS-1:0]   efpga_event_o
);

   logic [efpga_pkg::N_EVENTS-1:0] evt_meta_q;
   logic [efpga_pkg::N_EVENTS-1:0] evt_sync_q;
   logic [efpga_pkg::N_EVENTS-1:0] evt_gated;
   logic [efpga_pkg::N_EVENTS-1:0] evt_prev_q;

   // fabric drives these without reference to asic_clk_i
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         evt_meta_q <= '0;
         evt_sync_q <= '0;
      end else begin
         evt_meta_q <= fab_events_i;
         evt_sync_q <= evt_meta_q;
      end
   end

   assign evt_gated = evt_sync_q & {efpga_pkg::N_EVENTS{enable_events_i}};

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         evt_prev_q    <= '0;
         efpga_event_o <= '0;
      end else begin
         evt_prev_q    <= evt_gated;
         efpga_event_o <= evt_gated & ~evt_prev_q;   // rising edge only
      end
   end

endmodule

// ==== src/lint_wb_slave.sv ====
// Wishbone classic slave stage for the fabric register port
// registers one access, waits for the gate, pulses ack
`timescale 1ns/1ps

module lint_wb_slave (
   input  logic                                asic_clk_i,
   input  logic                                rst_n,
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_we_i,
   input  logic [efpga_pkg::LINT_ADDR_W-1:0]   wb_adr_i,
   input  logic [efpga_pkg::DATA_W-1:0]        wb_dat_i,
   input  logic [efpga_pkg::BE_W-1:0]          wb_sel_i,
   output logic [efpga_pkg::DATA_W-1:0]        wb_dat_o,
   output logic                                wb_ack_o,
   output efpga_pkg::lint_req_t                acc_req_o,
   output logic                                acc_valid_o,
   input  logic                                acc_done_i,
   input  efpga_pkg::lint_rsp_t                acc_rsp_i
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_BUSY,
      S_ACK
   } slv_state_t;

   slv_state_t state_q;
   logic       wb_start;

   assign wb_start = (state_q == S_IDLE) && wb_cyc_i && wb_stb_i;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= S_IDLE;
         acc_valid_o <= 1'b0;
         wb_ack_o    <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (wb_start) begin
                  acc_valid_o <= 1'b1;
                  state_q     <= S_BUSY;
               end
            end
            S_BUSY: begin
               if (acc_done_i) begin
                  acc_valid_o <= 1'b0;
                  wb_ack_o    <= 1'b1;
                  state_q     <= S_ACK;
               end
            end
            S_ACK: begin
               wb_ack_o <= 1'b0;
               // one extra cycle here so the acked cycle is not taken again
               if (!wb_ack_o) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge asic_clk_i) begin
      if (wb_start) begin
         acc_req_o.we    <= wb_we_i;
         acc_req_o.addr  <= wb_adr_i;
         acc_req_o.be    <= wb_sel_i;
         acc_req_o.wdata <= wb_dat_i;
      end
      if ((state_q == S_BUSY) && acc_done_i) begin
         wb_dat_o <= acc_rsp_i.rdata;   // valid with ack
      end
   end

endmodule

// ==== src/lint_access_gate.sv ====
// register port enable gate and fabric handshake
// settle delay, request until grant, wait for rvalid
`timescale 1ns/1ps

module lint_access_gate (
   input  logic                            asic_clk_i,
   input  logic                            rst_n,
   input  logic                            enable_apb_i,
   input  efpga_pkg::lint_req_t            acc_req_i,
   input  logic                            acc_valid_i,
   output logic                            acc_done_o,
   output efpga_pkg::lint_rsp_t            acc_rsp_o,
   output efpga_pkg::lint_req_t            fab_req_o,
   output logic                            fab_req_valid_o,
   input  logic                            fab_gnt_i,
   input  logic                            fab_rvalid_i,
   input  logic [efpga_pkg::DATA_W-1:0]    fab_rdata_i
);

   typedef enum logic [2:0] {
      G_IDLE,
      G_SETTLE,
      G_REQ,
      G_WAIT,
      G_DONE
   } gate_state_t;

   gate_state_t                         state_q;
   logic [efpga_pkg::SETTLE_CNT_W-1:0]  settle_cnt_q;
   logic                                acc_start;

   assign acc_start = (state_q == G_IDLE) && acc_valid_i;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state_q         <= G_IDLE;
         settle_cnt_q    <= '0;
         fab_req_valid_o <= 1'b0;
         acc_done_o      <= 1'b0;
      end else begin
         acc_done_o <= 1'b0;
         case (state_q)
            G_IDLE: begin
               if (acc_valid_i) begin
                  settle_cnt_q <= '0;
                  if (enable_apb_i) begin
                     state_q <= G_SETTLE;
                  end else begin
                     acc_done_o <= 1'b1;   // port off, complete at once
                     state_q    <= G_DONE;
                  end
               end
            end
            G_SETTLE: begin
               if (!enable_apb_i) begin
                  acc_done_o <= 1'b1;   // disabled while settling
                  state_q    <= G_DONE;
               end else if (settle_cnt_q == efpga_pkg::SETTLE_LAST) begin
                  fab_req_valid_o <= 1'b1;
                  state_q         <= G_REQ;
               end else begin
                  settle_cnt_q <= settle_cnt_q + 1'b1;
               end
            end
            G_REQ: begin
               if (fab_gnt_i) begin
                  fab_req_valid_o <= 1'b0;   // transfer cycle
                  state_q         <= G_WAIT;
               end
            end
            G_WAIT: begin
               if (fab_rvalid_i) begin
                  acc_done_o <= 1'b1;
                  state_q    <= G_DONE;
               end
            end
            // slave drops acc_valid_i on the done edge
            G_DONE: state_q <= G_IDLE;
            default: state_q <= G_IDLE;
         endcase
      end
   end

   always_ff @(posedge asic_clk_i) begin
      if (acc_start) begin
         fab_req_o <= acc_req_i;
         acc_rsp_o <= '0;   // zero unless the fabric answers
      end
      if ((state_q == G_WAIT) && fab_rvalid_i) begin
         acc_rsp_o.rdata <= fab_rdata_i;
      end
   end

endmodule

// ==== src/efpga_subsystem.sv ====
// eFPGA subsystem ASIC side glue
// control word filter, event sync, Wishbone register port
`timescale 1ns/1ps

module efpga_subsystem (
   input  logic                                asic_clk_i,
   input  logic                                rst_n,

   input  logic                                enable_apb_i,
   input  logic                                enable_events_i,

   input  logic [efpga_pkg::CTRL_W-1:0]        control_i,
   output logic [efpga_pkg::CTRL_W-1:0]        efpga_control_o,

   input  logic [efpga_pkg::N_EVENTS-1:0]      fab_events_i,
   output logic [efpga_pkg::N_EVENTS-1:0]      efpga_event_o,

   // SoC side Wishbone classic
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   input  logic                                wb_we_i,
   input  logic [efpga_pkg::LINT_ADDR_W-1:0]   wb_adr_i,
   input  logic [efpga_pkg::DATA_W-1:0]        wb_dat_i,
   input  logic [efpga_pkg::BE_W-1:0]          wb_sel_i,
   output logic [efpga_pkg::DATA_W-1:0]        wb_dat_o,
   output logic                                wb_ack_o,

   // fabric register port
   output efpga_pkg::lint_req_t                fab_req_o,
   output logic                                fab_req_valid_o,
   input  logic                                fab_gnt_i,
   input  logic                                fab_rvalid_i,
   input  logic [efpga_pkg::DATA_W-1:0]        fab_rdata_i
);

   efpga_pkg::lint_req_t acc_req;
   efpga_pkg::lint_rsp_t acc_rsp;
   logic                 acc_valid;
   logic                 acc_done;

   ctrl_word_filter u_ctrl_filter (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .control_i       (control_i),
      .efpga_control_o (efpga_control_o)
   );

   event_edge_sync u_event_sync (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .enable_events_i (enable_events_i),
      .fab_events_i    (fab_events_i),
      .efpga_event_o   (efpga_event_o)
   );

   lint_wb_slave u_wb_slave (
      .asic_clk_i  (asic_clk_i),
      .rst_n       (rst_n),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .acc_req_o   (acc_req),
      .acc_valid_o (acc_valid),
      .acc_done_i  (acc_done),
      .acc_rsp_i   (acc_rsp)
   );

   lint_access_gate u_access_gate (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .enable_apb_i    (enable_apb_i),
      .acc_req_i       (acc_req),
      .acc_valid_i     (acc_valid),
      .acc_done_o      (acc_done),
      .acc_rsp_o       (acc_rsp),
      .fab_req_o       (fab_req_o),
      .fab_req_valid_o (fab_req_valid_o),
      .fab_gnt_i       (fab_gnt_i),
      .fab_rvalid_i    (fab_rvalid_i),
      .fab_rdata_i     (fab_rdata_i)
   );

endmodule

// ==== dv/efpga_subsystem_assert.sv ====
// concurrent checks on the eFPGA subsystem ports
// bound into efpga_subsystem
`timescale 1ns/1ps

module efpga_subsystem_assert (
   input logic                             asic_clk_i,
   input logic                             rst_n,
   input logic                             enable_apb_i,
   input efpga_pkg::lint_req_t             fab_req_o,
   input logic                             fab_req_valid_o,
   input logic                             fab_gnt_i,
   input logic                             wb_ack_o,
   input logic [efpga_pkg::N_EVENTS-1:0]   efpga_event_o
);

   // request held steady until the fabric grants it
   req_held: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (fab_req_valid_o && !fab_gnt_i) |=> (fab_req_valid_o && $stable(fab_req_o)))
      else $error("fabric request dropped or changed before grant");

   ack_single: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      wb_ack_o |=> !wb_ack_o)
      else $error("wb_ack_o high for two cycles");

   event_single: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      !(|(efpga_event_o & $past(efpga_event_o))))
      else $error("efpga_event_o bit high for two cycles");

   // enable is sampled on the edge where the request rises
   req_needs_enable: assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      $rose(fab_req_valid_o) |-> $past(enable_apb_i))
      else $error("fabric request raised while the port was disabled");

endmodule

bind efpga_subsystem efpga_subsystem_assert u_assert (
   .asic_clk_i      (asic_clk_i),
   .rst_n           (rst_n),
   .enable_apb_i    (enable_apb_i),
   .fab_req_o       (fab_req_o),
   .fab_req_valid_o (fab_req_valid_o),
   .fab_gnt_i       (fab_gnt_i),
   .wb_ack_o        (wb_ack_o),
   .efpga_event_o   (efpga_event_o)
);

// ==== dv/tb_efpga_subsystem.sv ====
// testbench for the eFPGA subsystem glue
// Wishbone master, fabric register model, reference model and checks
`timescale 1ns/1ps

module tb_efpga_subsystem;

   localparam int N_RANDOM      = 120;
   localparam int N_DISABLED    = 16;
   localparam int ACCESS_MAX    = 16;   // worst case cycles per access
   localparam int TIMEOUT_LIMIT = (N_RANDOM + N_DISABLED + 32) * ACCESS_MAX + 1000;

   typedef struct packed {
      logic                          check;
      logic [efpga_pkg::DATA_W-1:0]  data;
   } expect_t;

   logic                                asic_clk_i = 1'b0;
   logic                                rst_n;
   logic                                enable_apb_i;
   logic                                enable_events_i;
   logic [efpga_pkg::CTRL_W-1:0]        control_i;
   logic [efpga_pkg::CTRL_W-1:0]        efpga_control_o;
   logic [efpga_pkg::N_EVENTS-1:0]      fab_events_i;
   logic [efpga_pkg::N_EVENTS-1:0]      efpga_event_o;
   logic                                wb_cyc_i;
   logic                                wb_stb_i;
   logic                                wb_we_i;
   logic [efpga_pkg::LINT_ADDR_W-1:0]   wb_adr_i;
   logic [efpga_pkg::DATA_W-1:0]        wb_dat_i;
   logic [efpga_pkg::BE_W-1:0]          wb_sel_i;
   logic [efpga_pkg::DATA_W-1:0]        wb_dat_o;
   logic                                wb_ack_o;
   efpga_pkg::lint_req_t                fab_req_o;
   logic                                fab_req_valid_o;
   logic                                fab_gnt_i;
   logic                                fab_rvalid_i;
   logic [efpga_pkg::DATA_W-1:0]        fab_rdata_i;

   logic [efpga_pkg::DATA_W-1:0] shadow_mem [16];
   logic [efpga_pkg::DATA_W-1:0] fab_mem [16];
   expect_t                      expect_q [$];

   int error_count = 0;
   int check_count = 0;
   int rd_errors   = 0;
   int rd_checks   = 0;
   int test_count  = 0;
   int cycle_count = 0;
   int req_cycles  = 0;

   efpga_subsystem UUT (.*);

   always #5 asic_clk_i = ~asic_clk_i;

   function automatic logic [31:0] fill_word(input int idx);
      return 32'hA5C3_0000 + (32'(idx) * 32'h0011_0101);
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  be);
      logic [31:0] result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   // expected read data and shadow update on enabled writes
   function automatic logic [31:0] ref_access(input logic        we,
                                              input logic [19:0] addr,
                                              input logic [3:0]  be,
                                              input logic [31:0] wdata,
                                              input logic        enabled);
      logic [3:0] idx;
      idx = addr[3:0];
      if (!enabled) return '0;   // reads return zero and writes drop
      if (we) begin
         shadow_mem[idx] = merge_bytes(shadow_mem[idx], wdata, be);
         return '0;
      end
      return shadow_mem[idx];
   endfunction

   function automatic int total_errors();
      return error_count + rd_errors;
   endfunction

   task automatic check_value(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      assert (got === exp) else begin
         $display("[FAIL] %0t %s got 0x%h expected 0x%h", $time, sig, got, exp);
         error_count++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      check_count++;
      assert (cond) else begin
         $display("error at %0t: %s", $time, what);
         error_count++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      int errs;
      errs = total_errors() - errs_before;
      test_count++;
      if (errs == 0) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errs);
   endtask

   // one Wishbone classic access from falling edge to falling edge
   task automatic wb_access(input logic we, input logic [19:0] addr,
                            input logic [3:0] be, input logic [31:0] data);
      expect_t exp;
      exp.data  = ref_access(we, addr, be, data, enable_apb_i);
      exp.check = !we || !enable_apb_i;
      expect_q.push_back(exp);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = addr;
      wb_dat_i = data;
      wb_sel_i = be;
      do @(negedge asic_clk_i); while (!wb_ack_o);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      @(negedge asic_clk_i);
   endtask

   task automatic event_pulse_check(input int bit_idx, input logic enabled);
      logic [15:0] exp;
      fab_events_i = 16'h1 << bit_idx;
      for (int k = 1; k <= 8; k++) begin
         @(negedge asic_clk_i);
         exp = (enabled && k == 3) ? (16'h1 << bit_idx) : 16'h0;   // pulse 3 cycles on
         check_value("efpga_event_o", 32'(efpga_event_o), 32'(exp));
      end
      fab_events_i = '0;
      for (int k = 0; k < 4; k++) begin
         @(negedge asic_clk_i);
         check_value("efpga_event_o", 32'(efpga_event_o), 32'h0);
      end
   endtask

   // fabric register port with random grant stall and rvalid latency
   initial begin : fabric_model
      efpga_pkg::lint_req_t req;
      int                   stall;
      int                   lat;
      fab_gnt_i    = 1'b0;
      fab_rvalid_i = 1'b0;
      fab_rdata_i  = '0;
      for (int i = 0; i < 16; i++) fab_mem[i] = fill_word(i);
      forever begin
         @(negedge asic_clk_i);
         if (fab_req_valid_o) begin
            stall = int'($urandom_range(3, 0));
            repeat (stall) @(negedge asic_clk_i);
            fab_gnt_i = 1'b1;
            req       = fab_req_o;
            @(negedge asic_clk_i);
            fab_gnt_i = 1'b0;
            if (req.we) begin
               fab_mem[req.addr[3:0]] = merge_bytes(fab_mem[req.addr[3:0]], req.wdata, req.be);
            end
            lat = int'($urandom_range(3, 1));
            repeat (lat - 1) @(negedge asic_clk_i);
            fab_rvalid_i = 1'b1;
            fab_rdata_i  = fab_mem[req.addr[3:0]];
            @(negedge asic_clk_i);
            fab_rvalid_i = 1'b0;
         end
      end
   end

   always @(negedge asic_clk_i) begin : read_compare
      expect_t exp;
      if (rst_n && wb_ack_o) begin
         assert (expect_q.size() != 0) else begin
            $display("error at %0t: ack with no access outstanding", $time);
            rd_errors++;
         end
         if (expect_q.size() != 0) begin
            exp = expect_q.pop_front();
            if (exp.check) begin
               rd_checks++;
               assert (wb_dat_o === exp.data) else begin
                  $display("[FAIL] %0t wb_dat_o got 0x%h expected 0x%h",
                           $time, wb_dat_o, exp.data);
                  rd_errors++;
               end
            end
         end
      end
   end

   always @(posedge asic_clk_i) begin
      if (fab_req_valid_o) req_cycles++;
   end

   always @(posedge asic_clk_i) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_LIMIT) begin
         $display("timeout after %0d cycles, a handshake never completed", cycle_count);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      int          errs_before;
      int          req_before;
      logic [31:0] w1;
      logic [31:0] w3;
      logic [31:0] glitch;
      logic        found;
      void'($urandom(32'h41cd));
      rst_n           = 1'b0;
      enable_apb_i    = 1'b0;
      enable_events_i = 1'b0;
      control_i       = '0;
      fab_events_i    = '0;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      wb_we_i         = 1'b0;
      wb_adr_i        = '0;
      wb_dat_i        = '0;
      wb_sel_i        = '0;
      for (int i = 0; i < 16; i++) shadow_mem[i] = fill_word(i);
      repeat (3) @(negedge asic_clk_i);
      rst_n = 1'b1;
      @(negedge asic_clk_i);

      errs_before = total_errors();
      check_value("wb_ack_o", 32'(wb_ack_o), 32'h0);
      check_value("fab_req_valid_o", 32'(fab_req_valid_o), 32'h0);
      check_value("efpga_event_o", 32'(efpga_event_o), 32'h0);
      check_value("efpga_control_o", efpga_control_o, 32'h0);
      end_test("reset", errs_before);

      errs_before  = total_errors();
      enable_apb_i = 1'b1;
      for (int n = 0; n < N_RANDOM; n++) begin
         wb_access(1'($urandom()), 20'($urandom()), 4'($urandom()), $urandom());
      end
      end_test("enabled_rw", errs_before);

      errs_before  = total_errors();
      enable_apb_i = 1'b0;
      req_before   = req_cycles;
      for (int n = 0; n < N_DISABLED; n++) begin
         wb_access(1'($urandom()), 20'($urandom()), 4'hF, $urandom());
      end
      check_true(req_cycles == req_before, "fab_req_valid_o rose while the port was disabled");
      enable_apb_i = 1'b1;
      for (int i = 0; i < 16; i++) begin
         wb_access(1'b0, {16'($urandom()), 4'(i)}, 4'hF, '0);   // words must be unchanged
      end
      end_test("disabled_port", errs_before);

      errs_before = total_errors();
      w1          = $urandom();
      w3          = w1 ^ 32'h0000_0001;
      glitch      = ~w1;
      control_i   = w1;
      found       = 1'b0;
      for (int k = 1; k <= 6; k++) begin
         @(negedge asic_clk_i);
         if (k <= 4 && efpga_control_o == w1) found = 1'b1;
      end
      check_true(found, "control word did not reach efpga_control_o within 4 cycles");
      check_value("efpga_control_o", efpga_control_o, w1);
      control_i = glitch;   // one cycle only
      @(negedge asic_clk_i);
      found     = (efpga_control_o == glitch);
      control_i = w3;
      for (int k = 0; k < 8; k++) begin
         @(negedge asic_clk_i);
         if (efpga_control_o == glitch) found = 1'b1;
      end
      check_true(!found, "one cycle glitch reached efpga_control_o");
      check_value("efpga_control_o", efpga_control_o, w3);
      end_test("control_filter", errs_before);

      errs_before     = total_errors();
      enable_events_i = 1'b1;
      repeat (3) @(negedge asic_clk_i);
      for (int n = 0; n < 3; n++) begin
         event_pulse_check(int'($urandom_range(15, 0)), 1'b1);
      end
      enable_events_i = 1'b0;
      for (int n = 0; n < 2; n++) begin
         event_pulse_check(int'($urandom_range(15, 0)), 1'b0);
      end
      end_test("event_pulse", errs_before);

      $display("summary: %0d tests, %0d checks, %0d errors",
               test_count, check_count + rd_checks, total_errors());
      if (total_errors() == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== efpga_subsystem.f ====
src/efpga_pkg.sv
src/ctrl_word_filter.sv
src/event_edge_sync.sv
src/lint_wb_slave.sv
src/lint_access_gate.sv
src/efpga_subsystem.sv
dv/efpga_subsystem_assert.sv
dv/tb_efpga_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the eFPGA subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_efpga_subsystem \
   -f efpga_subsystem.f -o sim_efpga

out=$(./obj_dir/sim_efpga)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Regression passed"
